// File: rtl/rvcore_params.svh
// width and reset-address macros shared by the rv32i core, pulled in with `include
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// register address width, 32 architectural registers
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

`endif

// File: rtl/rvcore_pkg.sv
// shared enums and packed structs for the rv32i core, imported by the decode, alu and top
`include "rvcore_params.svh"

package rvcore_pkg;

    // rv32i major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B   // lui, operand b straight through
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE
    } br_op_e;

    // decode result, one per instruction
    typedef struct packed {
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_wen;
        alu_op_e               alu_op;
        logic                  src_a_pc;   // 1: operand a is pc
        logic                  src_b_imm;  // 1: operand b is the immediate
        br_op_e                br_op;
        logic                  jal;
        logic                  jalr;
        logic                  ebreak;
        logic                  illegal;
        logic [`RV_XLEN-1:0]   imm;
    } ctrl_t;

    // retirement trace record, difftest style
    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic [31:0]           inst;
        logic [`RV_REG_AW-1:0] rd;
        logic                  wen;
        logic [`RV_XLEN-1:0]   wdata;
    } commit_t;

endpackage

// File: rtl/rvcore_fetch.sv
// pc register with next-pc mux and halt latch, instantiated once by the core top level
`timescale 1ns/1ps
`include "rvcore_params.svh"

module rvcore_fetch (
    input  logic                clk,
    input  logic                rst,
    input  rvcore_pkg::ctrl_t   ctrl,
    input  logic                br_taken,
    input  logic [`RV_XLEN-1:0] alu_res,
    output logic [`RV_XLEN-1:0] pc,
    output logic                halted,
    output logic                illegal
);

    logic [`RV_XLEN-1:0] next_pc;
    logic                halt_now;

    assign halt_now = ctrl.ebreak | ctrl.illegal;

    always_comb begin
        if (ctrl.jalr) begin
            next_pc = {alu_res[`RV_XLEN-1:1], 1'b0};  // rs1 + imm, lsb cleared
        end else if (ctrl.jal || br_taken) begin
            next_pc = pc + ctrl.imm;
        end else begin
            next_pc = pc + `RV_XLEN'd4;
        end
    end

    // halting instruction still advances pc once, then everything holds
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= `RV_RESET_PC;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else if (!halted) begin
            pc      <= next_pc;
            halted  <= halt_now;
            illegal <= ctrl.illegal;  // keeps the halt cause visible
        end
    end

endmodule

// File: rtl/rvcore_decode.sv
// rv32i subset decoder and immediate generator, purely combinational, used by the core top level
`timescale 1ns/1ps
`include "rvcore_params.svh"

module rvcore_decode (
    input  logic [31:0]       inst,
    output rvcore_pkg::ctrl_t ctrl
);

    import rvcore_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    imm_sel_e    imm_sel;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // place and sign extend the immediate for one format
    function automatic logic [`RV_XLEN-1:0] imm_gen(input logic [31:0] ins, input imm_sel_e sel);
        logic [`RV_XLEN-1:0] v;
        case (sel)
            IMM_B:   v = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            IMM_U:   v = {ins[31:12], 12'b0};
            IMM_J:   v = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: v = {{20{ins[31]}}, ins[31:20]};  // I-type
        endcase
        return v;
    endfunction

    always_comb begin
        ctrl         = '0;
        ctrl.rs1     = inst[19:15];
        ctrl.rs2     = inst[24:20];
        ctrl.rd      = inst[11:7];
        ctrl.alu_op  = ALU_ADD;
        ctrl.br_op   = BR_NONE;
        imm_sel      = IMM_I;

        case (opcode)
            OPC_OP: begin
                ctrl.reg_wen = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    default: ctrl.illegal = 1'b1;  // shifts not supported
                endcase
                // only sub may set funct7
                if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    ctrl.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.src_b_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_ADD;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.src_b_imm = 1'b1;
                imm_sel        = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                imm_sel        = IMM_U;
            end
            OPC_JAL: begin
                ctrl.reg_wen = 1'b1;
                ctrl.jal     = 1'b1;
                imm_sel      = IMM_J;  // target computed in fetch
            end
            OPC_JALR: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.src_b_imm = 1'b1;  // alu forms rs1 + imm
                ctrl.illegal   = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm_sel = IMM_B;
                case (funct3)
                    3'b000:  ctrl.br_op = BR_EQ;
                    3'b001:  ctrl.br_op = BR_NE;
                    3'b100:  ctrl.br_op = BR_LT;
                    3'b101:  ctrl.br_op = BR_GE;
                    default: ctrl.illegal = 1'b1;  // bltu/bgeu left out
                endcase
            end
            OPC_SYSTEM: begin
                // ebreak is the only system instruction handled
                if (inst == 32'h0010_0073) begin
                    ctrl.ebreak = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase

        if (ctrl.illegal) begin
            ctrl.reg_wen = 1'b0;
            ctrl.br_op   = BR_NONE;
            ctrl.jal     = 1'b0;
            ctrl.jalr    = 1'b0;
        end

        ctrl.imm = imm_gen(inst, imm_sel);
    end

endmodule

// File: rtl/rvcore_regfile.sv
// 32 x 32-bit integer register file, two async read ports and one write port, x0 reads zero
`timescale 1ns/1ps
`include "rvcore_params.svh"

module rvcore_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2,
    input  logic                  wen,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata
);

    logic [`RV_XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write is not forwarded, single cycle core never needs it
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rtl/rvcore_alu.sv
// operand mux, integer alu and branch compare for the single cycle core
`timescale 1ns/1ps
`include "rvcore_params.svh"

module rvcore_alu (
    input  rvcore_pkg::ctrl_t   ctrl,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rdata1,
    input  logic [`RV_XLEN-1:0] rdata2,
    output logic [`RV_XLEN-1:0] alu_res,
    output logic                br_taken
);

    import rvcore_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;

    assign op_a = ctrl.src_a_pc  ? pc       : rdata1;
    assign op_b = ctrl.src_b_imm ? ctrl.imm : rdata2;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // compares always use the register values, never the immediate
    always_comb begin
        case (ctrl.br_op)
            BR_EQ:   br_taken = (rdata1 == rdata2);
            BR_NE:   br_taken = (rdata1 != rdata2);
            BR_LT:   br_taken = ($signed(rdata1) < $signed(rdata2));
            BR_GE:   br_taken = ($signed(rdata1) >= $signed(rdata2));
            default: br_taken = 1'b0;
        endcase
    end

endmodule

// File: rtl/rvcore_commit.sv
// writeback select plus registered commit trace and retired-instruction counter, output side of the core
`timescale 1ns/1ps
`include "rvcore_params.svh"

module rvcore_commit (
    input  logic                 clk,
    input  logic                 rst,
    input  rvcore_pkg::ctrl_t    ctrl,
    input  logic [31:0]          inst,
    input  logic [`RV_XLEN-1:0]  pc,
    input  logic [`RV_XLEN-1:0]  alu_res,
    input  logic                 halted,
    output logic                 wen,
    output logic [`RV_XLEN-1:0]  wdata,
    output rvcore_pkg::commit_t  commit,
    output logic [31:0]          instret
);

    assign wen   = ctrl.reg_wen & ~halted;
    assign wdata = (ctrl.jal || ctrl.jalr) ? pc + `RV_XLEN'd4 : alu_res;  // link address

    always_ff @(posedge clk) begin
        if (rst) begin
            commit.valid <= 1'b0;
            instret      <= '0;
        end else begin
            commit.valid <= ~halted;
            if (!halted) begin
                instret <= instret + 32'd1;
            end
        end
    end

    // trace payload, only meaningful while valid
    always_ff @(posedge clk) begin
        if (!halted) begin
            commit.pc    <= pc;
            commit.inst  <= inst;
            commit.rd    <= ctrl.rd;
            commit.wen   <= wen;
            commit.wdata <= wdata;
        end
    end

endmodule

// File: rtl/rvcore_top.sv
// single cycle rv32i core top, fetches over a combinational pc/inst port and emits a commit trace
`timescale 1ns/1ps
`include "rvcore_params.svh"

module rvcore_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         inst,
    output logic [`RV_XLEN-1:0] pc,
    output rvcore_pkg::commit_t commit,
    output logic [31:0]         instret,
    output logic                halted,
    output logic                illegal
);

    import rvcore_pkg::*;

    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    logic [`RV_XLEN-1:0] alu_res;
    logic                br_taken;
    logic                wen;
    logic [`RV_XLEN-1:0] wdata;

    rvcore_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .br_taken (br_taken),
        .alu_res  (alu_res),
        .pc       (pc),
        .halted   (halted),
        .illegal  (illegal)
    );

    rvcore_decode u_decode (
        .inst (inst),
        .ctrl (ctrl)
    );

    rvcore_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wen),
        .waddr  (ctrl.rd),
        .wdata  (wdata)
    );

    rvcore_alu u_alu (
        .ctrl     (ctrl),
        .pc       (pc),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .alu_res  (alu_res),
        .br_taken (br_taken)
    );

    rvcore_commit u_commit (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .inst    (inst),
        .pc      (pc),
        .alu_res (alu_res),
        .halted  (halted),
        .wen     (wen),
        .wdata   (wdata),
        .commit  (commit),
        .instret (instret)
    );

endmodule

// File: sim/rvcore_tb.sv
// self-checking testbench for the rv32i core that runs short programs against a reference model
`timescale 1ns/1ps
`include "rvcore_params.svh"

module rvcore_tb;

    import rvcore_pkg::*;

    localparam int          MEM_WORDS   = 256;
    localparam int          MAX_STEPS   = 64;
    localparam int          NUM_PROGS   = 4;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // one expected retirement
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] wdata;
    } retire_t;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] pc;
    commit_t     commit;
    logic [31:0] instret;
    logic        halted;
    logic        illegal;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] mem_idx;
    logic [31:0] lcg_state = 32'd80382;
    retire_t     exp_q[$];
    retire_t     exp_e;
    int          exp_total;
    logic        exp_illegal;
    int          fill_idx;
    int          prog_sel;
    string       test_name;
    int          errors;
    int          checked;
    int          commit_cnt;
    logic        rst_q;
    logic        halted_q;
    logic [31:0] pc_q;

    rvcore_top UUT (
        .clk     (clk),
        .rst     (rst),
        .inst    (inst),
        .pc      (pc),
        .commit  (commit),
        .instret (instret),
        .halted  (halted),
        .illegal (illegal)
    );

    always #4 clk = ~clk;

    // zero-wait instruction memory on the fetch path
    assign mem_idx = (pc - `RV_RESET_PC) >> 2;
    assign inst    = (mem_idx < MEM_WORDS) ? mem[mem_idx[7:0]] : 32'h0;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic place(input logic [31:0] word);
        mem[fill_idx] = word;
        fill_idx++;
    endtask

    task automatic place_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                input logic [4:0] rs2, input int target);
        logic [12:0] off;
        off = 13'((target - fill_idx) * 4);
        place(enc_b(off, rs2, rs1, f3));
    endtask

    task automatic place_jal(input logic [4:0] rd, input int target);
        logic [20:0] off;
        off = 21'((target - fill_idx) * 4);
        place(enc_j(off, rd));
    endtask

    task automatic build_arith();
        logic [31:0] r;
        logic [31:0] q;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        for (int i = 1; i < 8; i++) begin
            r = lcg_next();
            place(enc_u(r[31:12], 5'(i), OPC_LUI));
            place(enc_i(r[11:0], 5'(i), 3'b000, 5'(i), OPC_OP_IMM));
        end
        for (int n = 0; n < 24; n++) begin
            r   = lcg_next();
            q   = lcg_next();
            rd  = 5'd1 + 5'(r[27:25] % 3'd7);  // x1..x7
            rs1 = {2'b00, r[24:22]};
            rs2 = {2'b00, r[21:19]};
            case (r[31:28])
                4'd0:    place(enc_r(7'h00, rs2, rs1, 3'b000, rd));
                4'd1:    place(enc_r(7'h20, rs2, rs1, 3'b000, rd));
                4'd2:    place(enc_r(7'h00, rs2, rs1, 3'b111, rd));
                4'd3:    place(enc_r(7'h00, rs2, rs1, 3'b110, rd));
                4'd4:    place(enc_r(7'h00, rs2, rs1, 3'b100, rd));
                4'd5:    place(enc_r(7'h00, rs2, rs1, 3'b010, rd));
                4'd6:    place(enc_r(7'h00, rs2, rs1, 3'b011, rd));
                4'd7:    place(enc_i(q[31:20], rs1, 3'b000, rd, OPC_OP_IMM));
                4'd8:    place(enc_i(q[31:20], rs1, 3'b111, rd, OPC_OP_IMM));
                4'd9:    place(enc_i(q[31:20], rs1, 3'b110, rd, OPC_OP_IMM));
                4'd10:   place(enc_i(q[31:20], rs1, 3'b100, rd, OPC_OP_IMM));
                4'd11:   place(enc_i(q[31:20], rs1, 3'b010, rd, OPC_OP_IMM));
                4'd12:   place(enc_u(q[31:12], rd, OPC_AUIPC));
                default: place(enc_u(q[31:12], rd, OPC_LUI));
            endcase
        end
        place(EBREAK_WORD);
    endtask

    task automatic build_x0();
        logic [31:0] r;
        r = lcg_next();
        place(enc_i(r[31:20], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        place(enc_i(12'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));   // addi x0, x1, 5
        place(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        place(enc_u(r[19:0], 5'd0, OPC_LUI));
        place(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd2));         // x2 must equal x1
        place(enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd3));
        place(enc_r(7'h20, 5'd1, 5'd0, 3'b000, 5'd4));
        place(EBREAK_WORD);
    endtask

    task automatic build_control();
        logic [11:0] v;
        logic [11:0] nv;
        logic [31:0] skip;
        v    = 12'(lcg_next() % 32'd1000) + 12'd1;
        nv   = ~v + 12'd1;
        skip = enc_i(12'd1, 5'd0, 3'b000, 5'd10, OPC_OP_IMM);  // must never retire
        place(enc_i(nv, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));     // 0: x1 = -v
        place(enc_i(v, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));      // 1: x2 = v
        place(enc_i(nv, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));     // 2: x3 = -v
        place_branch(3'b000, 5'd1, 5'd3, 5);                  // 3: beq taken
        place(skip);
        place_branch(3'b000, 5'd1, 5'd2, 7);                  // 5: beq untaken
        place_branch(3'b001, 5'd1, 5'd2, 8);                  // 6: bne taken
        place(skip);
        place_branch(3'b001, 5'd1, 5'd3, 10);                 // 8: bne untaken
        place_branch(3'b100, 5'd1, 5'd2, 11);                 // 9: blt taken when signed
        place(skip);
        place_branch(3'b100, 5'd2, 5'd1, 13);                 // 11: blt untaken
        place_branch(3'b101, 5'd2, 5'd1, 14);                 // 12: bge taken
        place(skip);
        place_branch(3'b101, 5'd1, 5'd2, 16);                 // 14: bge untaken
        place_jal(5'd5, 17);                                  // 15
        place(skip);
        place(enc_u(20'h0, 5'd6, OPC_AUIPC));                 // 17: x6 = own pc
        place(enc_i(12'd13, 5'd6, 3'b000, 5'd7, OPC_JALR));   // 18: odd target with lsb dropped
        place(skip);
        place(enc_r(7'h00, 5'd7, 5'd5, 3'b000, 5'd8));        // 20: sum of both links
        place_jal(5'd0, 23);                                  // 21
        place(EBREAK_WORD);                                   // 22
        place_branch(3'b000, 5'd0, 5'd0, 22);                 // 23: backward
    endtask

    task automatic build_illegal();
        place(enc_i(12'd7, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        place(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        place(enc_i(12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011));  // lw, not supported
        place(enc_i(12'd1, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
        place(EBREAK_WORD);
    endtask

    // ISA-level model that fills exp_q with every retirement up to the halt
    task automatic run_model();
        logic [31:0] x [0:31];
        logic [31:0] mpc;
        logic [31:0] ins;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] npc;
        logic [31:0] widx;
        logic        wr;
        logic        bad;
        logic        stop;
        logic        take;
        retire_t     r;
        int          step;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        exp_q.delete();
        exp_illegal = 1'b0;
        mpc  = `RV_RESET_PC;
        stop = 1'b0;
        step = 0;
        while (!stop && step < MAX_STEPS) begin
            widx  = (mpc - `RV_RESET_PC) >> 2;
            ins   = (widx < MEM_WORDS) ? mem[widx[7:0]] : 32'h0;
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            res   = '0;
            wr    = 1'b1;
            bad   = 1'b0;
            take  = 1'b0;
            npc   = mpc + 32'd4;
            case (ins[6:0])
                OPC_OP: begin
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_010: res = {31'b0, $signed(a) < $signed(b)};
                        10'b0000000_011: res = {31'b0, a < b};
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_111: res = a & b;
                        default:         bad = 1'b1;
                    endcase
                end
                OPC_OP_IMM: begin
                    case (ins[14:12])
                        3'b000:  res = a + imm_i;
                        3'b010:  res = {31'b0, $signed(a) < $signed(imm_i)};
                        3'b100:  res = a ^ imm_i;
                        3'b110:  res = a | imm_i;
                        3'b111:  res = a & imm_i;
                        default: bad = 1'b1;
                    endcase
                end
                OPC_LUI:   res = {ins[31:12], 12'h0};
                OPC_AUIPC: res = mpc + {ins[31:12], 12'h0};
                OPC_JAL: begin
                    res = mpc + 32'd4;
                    npc = mpc + imm_j;
                end
                OPC_JALR: begin
                    bad = (ins[14:12] != 3'b000);
                    res = mpc + 32'd4;
                    npc = (a + imm_i) & ~32'h1;  // before rd is written
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'b000:  take = (a == b);
                        3'b001:  take = (a != b);
                        3'b100:  take = ($signed(a) < $signed(b));
                        3'b101:  take = ($signed(a) >= $signed(b));
                        default: bad = 1'b1;
                    endcase
                    if (take) begin
                        npc = mpc + imm_b;
                    end
                end
                OPC_SYSTEM: begin
                    wr   = 1'b0;
                    stop = 1'b1;
                    bad  = (ins != EBREAK_WORD);
                end
                default: bad = 1'b1;
            endcase
            if (bad) begin
                wr          = 1'b0;
                stop        = 1'b1;
                exp_illegal = 1'b1;
            end
            r.pc    = mpc;
            r.inst  = ins;
            r.rd    = ins[11:7];
            r.wen   = wr;
            r.wdata = res;
            exp_q.push_back(r);
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            mpc = npc;
            step++;
        end
        exp_total = exp_q.size();
    endtask

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        errors++;
        $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    // reset, load one program, run it to the halt and let it settle
    task automatic run_program(input string name, input int sel);
        @(posedge clk);
        rst      <= 1'b1;
        prog_sel <= sel;
        @(posedge clk);
        test_name = name;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[24:0], 7'b0000000};  // stray fetch decodes as illegal
        end
        fill_idx = 0;
        case (prog_sel)
            0:       build_arith();
            1:       build_x0();
            2:       build_control();
            default: build_illegal();
        endcase
        run_model();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        while (!halted) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        assert (exp_q.size() == 0)
            else report_fault("program halted before all expected commits appeared");
    endtask

    // output checks sampled mid-cycle
    always @(negedge clk) begin
        if (rst_q) begin
            assert (pc == `RV_RESET_PC) else report_value("reset pc", `RV_RESET_PC, pc);
            assert (!commit.valid && !halted && !illegal)
                else report_fault("commit valid or status flag set during reset");
            assert (instret == 32'd0) else report_value("reset instret", 32'd0, instret);
            commit_cnt = 0;
            halted_q   = 1'b0;
        end else if (!rst) begin
            assert (commit.valid || halted_q) else report_fault("no commit in a running cycle");
            if (commit.valid) begin
                commit_cnt++;
                checked++;
                if (exp_q.size() == 0) begin
                    report_fault("commit arrived with no retirement left in the model");
                end else begin
                    exp_e = exp_q.pop_front();
                    assert (commit.pc == exp_e.pc)
                        else report_value("commit pc", exp_e.pc, commit.pc);
                    assert (commit.pc == pc_q)
                        else report_value("commit pc lag", pc_q, commit.pc);
                    assert (commit.inst == exp_e.inst)
                        else report_value("commit inst", exp_e.inst, commit.inst);
                    assert (commit.rd == exp_e.rd)
                        else report_value("commit rd", 32'(exp_e.rd), 32'(commit.rd));
                    assert (commit.wen == exp_e.wen)
                        else report_value("commit wen", 32'(exp_e.wen), 32'(commit.wen));
                    if (exp_e.wen) begin
                        assert (commit.wdata == exp_e.wdata)
                            else report_value("commit wdata", exp_e.wdata, commit.wdata);
                    end
                    assert (instret == 32'(commit_cnt))
                        else report_value("instret", 32'(commit_cnt), instret);
                end
            end
            if (halted && halted_q) begin
                assert (!commit.valid) else report_fault("commit seen after halt");
                assert (pc == pc_q) else report_value("halted pc", pc_q, pc);
                assert (instret == 32'(exp_total))
                    else report_value("final instret", 32'(exp_total), instret);
                assert (illegal == exp_illegal)
                    else report_value("illegal flag", 32'(exp_illegal), 32'(illegal));
            end
            halted_q = halted;
        end
        rst_q = rst;
        pc_q  = pc;
    end

    // each program takes reset, at most MAX_STEPS retirements and settle time
    initial begin
        #(NUM_PROGS * (MAX_STEPS + 12) * 8 + 200);
        $display("watchdog expired, the DUT did not reach a halt in time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        rst_q       = 1'b1;  // first edge already sees rst high
        halted_q    = 1'b0;
        pc_q        = '0;
        prog_sel    = 0;
        errors      = 0;
        checked     = 0;
        commit_cnt  = 0;
        exp_total   = 0;
        exp_illegal = 1'b0;
        test_name   = "reset";
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[24:0], 7'b0000000};
        end
        run_program("arith", 0);
        run_program("x0", 1);
        run_program("control", 2);
        run_program("illegal", 3);
        $display("summary: %0d commits checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/rvcore_pkg.sv
rtl/rvcore_fetch.sv
rtl/rvcore_decode.sv
rtl/rvcore_regfile.sv
rtl/rvcore_alu.sv
rtl/rvcore_commit.sv
rtl/rvcore_top.sv
sim/rvcore_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := rvcore_tb
FILELIST := src.f
LOG      := sim.log
PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
